// ==== list.f ====
+incdir+src
src/branch_pkg.sv
src/bus_pkg.sv
src/bht_ram.sv
src/return_stack.sv
src/branch_predictor.sv
sim/tb_branch_predictor.sv

// ==== sim/tb_branch_predictor.sv ====
`timescale 1ns/1ps
`include "bpu_params.svh"

module tb_branch_predictor
    import branch_pkg::*;
    import bus_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    fetch_req_t  fetch_req;
    logic        fetch_ready;
    prediction_t prediction;
    verify_t     verify;
    redirect_t   redirect;

    // reference model state
    bht_entry_t  model_tab [int];
    virt_t       ras_model [$];
    logic        m_correct;
    virt_t       m_redirect;
    logic        exp_valid;
    virt_t       exp_pc;
    logic        exp_br_op;
    logic        exp_taken;
    virt_t       exp_target;
    bht_entry_t  exp_entry;

    logic [31:0] seed = 32'hcff0cdab;
    int          errors;
    int          errors_at_start;
    int          pass_count;
    int          fail_count;
    virt_t       pc_c;
    virt_t       tgt_c;
    virt_t       pc_call;
    virt_t       tgt_call;
    virt_t       pc_ret;
    virt_t       pc_alias;
    virt_t       pc_f;
    virt_t       tgt_f;

    branch_predictor i_branch_predictor (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready),
        .prediction  (prediction),
        .verify      (verify),
        .redirect    (redirect)
    );

    always #10 clk = ~clk;

    task automatic report_diff(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
        errors++;
    endtask

    // outputs are checked mid-cycle where nothing moves
    a_ready: assert property (@(negedge clk) disable iff (rst) fetch_ready == !m_correct)
        else report_diff("fetch_ready", !m_correct, fetch_ready);
    a_pvalid: assert property (@(negedge clk) disable iff (rst) prediction.valid == exp_valid)
        else report_diff("prediction.valid", exp_valid, prediction.valid);
    a_pc: assert property (@(negedge clk) disable iff (rst) !exp_valid || prediction.pc == exp_pc)
        else report_diff("prediction.pc", exp_pc, prediction.pc);
    a_br_op: assert property (@(negedge clk) disable iff (rst)
                              !exp_valid || prediction.br_op == exp_br_op)
        else report_diff("prediction.br_op", exp_br_op, prediction.br_op);
    a_taken: assert property (@(negedge clk) disable iff (rst)
                              !exp_valid || prediction.taken == exp_taken)
        else report_diff("prediction.taken", exp_taken, prediction.taken);
    a_target: assert property (@(negedge clk) disable iff (rst)
                               !exp_valid || prediction.target == exp_target)
        else report_diff("prediction.target", exp_target, prediction.target);
    a_entry: assert property (@(negedge clk) disable iff (rst)
                              !(exp_valid && exp_br_op) || prediction.entry == exp_entry)
        else report_diff("prediction.entry", exp_entry, prediction.entry);
    a_rvalid: assert property (@(negedge clk) disable iff (rst)
                               redirect.valid == (m_correct && !flush))
        else report_diff("redirect.valid", m_correct && !flush, redirect.valid);
    a_rtarget: assert property (@(negedge clk) disable iff (rst)
                                !m_correct || redirect.target == m_redirect)
        else report_diff("redirect.target", m_redirect, redirect.target);

    function automatic virt_t rand_addr();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed & 32'hffff_fffc;
    endfunction

    function automatic bht_entry_t model_read(input virt_t pc);
        int idx;
        idx = int'(pc[`BHT_IDX_W+1:2]);
        if (model_tab.exists(idx)) begin
            return model_tab[idx];
        end
        return '0;
    endfunction

    function automatic ctr_e saturate_step(input ctr_e c, input logic taken);
        if (taken && c != ctr_st) return ctr_e'(c + 2'd1);
        if (!taken && c != ctr_snt) return ctr_e'(c - 2'd1);
        return c;
    endfunction

    // advance the model by one clock edge with what was driven and clear inputs
    task automatic step();
        bht_entry_t e;
        bht_entry_t w;
        logic       hit;
        logic       accept;
        @(posedge clk);
        #2;
        accept    = fetch_req.valid && !m_correct;
        exp_valid = accept && !flush;
        if (accept) begin
            e          = model_read(fetch_req.pc);
            hit        = e.br_type != br_none &&
                         e.tag == fetch_req.pc[`BPU_ADDR_W-1:`BHT_IDX_W+2];
            exp_pc     = fetch_req.pc;
            exp_br_op  = hit;
            exp_entry  = e;
            exp_taken  = 1'b0;
            exp_target = fetch_req.pc + 32'd8;
            if (hit && (e.br_type == br_jump || e.br_type == br_call ||
                        (e.br_type == br_cond && e.count[1]))) begin
                exp_taken  = 1'b1;
                exp_target = e.target;
            end
            if (hit && e.br_type == br_call) begin
                ras_model.push_back(fetch_req.pc + 32'd8);
                if (ras_model.size() > `RAS_DEPTH) void'(ras_model.pop_front());
            end
            if (hit && e.br_type == br_return && ras_model.size() > 0) begin
                exp_taken  = 1'b1;
                exp_target = ras_model.pop_back();
            end
        end
        if (verify.valid) begin
            w.tag     = verify.pc[`BPU_ADDR_W-1:`BHT_IDX_W+2];
            w.br_type = verify.actual_type;
            w.target  = verify.correct_target;
            if (verify.predict_ok) w.count = saturate_step(verify.entry.count, verify.taken);
            else w.count = verify.taken ? ctr_wt : ctr_wnt;
            model_tab[int'(verify.pc[`BHT_IDX_W+1:2])] = w;
        end
        if (flush || m_correct) begin
            m_correct = 1'b0;
        end else if (verify.valid && !verify.predict_ok) begin
            m_correct  = 1'b1;
            m_redirect = verify.correct_target;
        end
        fetch_req = '0;
        verify    = '0;
        flush     = 1'b0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!fetch_ready) begin
            if (n == 4) begin
                $display("timeout: fetch_ready stayed low at %0t", $time);
                errors++;
                break;
            end
            step();
            n++;
        end
    endtask

    task automatic wait_redirect();
        int n;
        n = 0;
        while (!redirect.valid) begin
            if (n == 4) begin
                $display("timeout: no redirect after a mispredicted verify at %0t", $time);
                errors++;
                break;
            end
            step();
            n++;
        end
    endtask

    task automatic lookup(input virt_t pc);
        wait_ready();
        fetch_req.valid = 1'b1;
        fetch_req.pc    = pc;
        step();
    endtask

    task automatic send_verify(input virt_t pc, input br_type_e typ, input logic taken,
                               input virt_t target, input logic ok);
        verify.valid          = 1'b1;
        verify.pc             = pc;
        verify.entry          = model_read(pc);
        verify.actual_type    = typ;
        verify.taken          = taken;
        verify.correct_target = target;
        verify.predict_ok     = ok;
    endtask

    // mispredicted taken report and the correction cycle after it
    task automatic train(input virt_t pc, input br_type_e typ, input virt_t target);
        send_verify(pc, typ, 1'b1, target, 1'b0);
        step();
        wait_redirect();
        wait_ready();
    endtask

    task automatic report_test(input string name);
        @(negedge clk);
        #1;
        if (errors == errors_at_start) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
        // back in step with the rising edge for the next test
        step();
    endtask

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        fetch_req = '0;
        verify    = '0;
        m_correct = 1'b0;
        exp_valid = 1'b0;
        model_tab.delete();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < 6; i++) begin
            lookup(rand_addr());
        end
        step();
        report_test("reset and cold lookups");

        pc_c  = rand_addr();
        tgt_c = rand_addr();
        lookup(pc_c);
        train(pc_c, br_cond, tgt_c);
        lookup(pc_c);
        send_verify(pc_c, br_cond, 1'b0, tgt_c, 1'b1);
        step();
        lookup(pc_c);
        step();
        report_test("conditional training");

        pc_call  = rand_addr();
        tgt_call = rand_addr();
        pc_ret   = pc_call + 32'd16;
        train(pc_call, br_call, tgt_call);
        train(pc_ret, br_return, rand_addr());
        lookup(pc_ret);
        lookup(pc_call);
        lookup(pc_ret);
        step();
        report_test("calls and returns");

        // same index with another tag
        pc_alias = pc_c ^ (32'h1 << (`BHT_IDX_W + 2));
        lookup(pc_alias);
        lookup(pc_c);
        lookup(pc_alias);
        step();
        report_test("aliasing and back-to-back");

        pc_f  = rand_addr();
        tgt_f = rand_addr();
        wait_ready();
        send_verify(pc_f, br_cond, 1'b1, tgt_f, 1'b0);
        fetch_req.valid = 1'b1;
        fetch_req.pc    = pc_f;
        step();
        flush = 1'b1;
        step();
        wait_ready();
        lookup(pc_f);
        // flush together with an accepted request and a mispredict
        wait_ready();
        send_verify(pc_f, br_cond, 1'b0, tgt_f, 1'b0);
        fetch_req.valid = 1'b1;
        fetch_req.pc    = pc_f;
        flush           = 1'b1;
        step();
        lookup(pc_f);
        step();
        report_test("flush");

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src/bht_ram.sv ====
`timescale 1ns/1ps
`include "bpu_params.svh"

module bht_ram
    import branch_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  logic [`BHT_IDX_W-1:0] waddr,
    input  bht_entry_t            wdata,
    input  logic [`BHT_IDX_W-1:0] raddr,
    output bht_entry_t            rdata
);

    localparam int DEPTH = 1 << `BHT_IDX_W;

    bht_entry_t mem [DEPTH];

    // only the type field is cleared, a none entry never hits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i].br_type <= br_none;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // combinational read, sees old contents during a write
    assign rdata = mem[raddr];

endmodule

// ==== src/bpu_params.svh ====
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// virtual address width
`define BPU_ADDR_W 32

// branch history table
// index taken from pc[BHT_IDX_W+1:2], word aligned
`define BHT_IDX_W 8

// tag covers every address bit above the index
`define BHT_TAG_W (`BPU_ADDR_W - `BHT_IDX_W - 2)

// return address stack
`define RAS_DEPTH 8
`define RAS_PTR_W 3

`endif

// ==== src/branch_pkg.sv ====
`include "bpu_params.svh"

package branch_pkg;

    // one virtual address word
    typedef logic [`BPU_ADDR_W-1:0] virt_t;

    // kind of control transfer held in a table entry
    typedef enum logic [2:0] {
        br_none   = 3'd0,
        br_cond   = 3'd1,
        br_jump   = 3'd2,
        br_call   = 3'd3,
        br_return = 3'd4
    } br_type_e;

    // 2-bit saturating counter, high bit means taken
    typedef enum logic [1:0] {
        ctr_snt = 2'd0,
        ctr_wnt = 2'd1,
        ctr_wt  = 2'd2,
        ctr_st  = 2'd3
    } ctr_e;

    // one branch history table entry
    typedef struct packed {
        logic [`BHT_TAG_W-1:0] tag;
        br_type_e              br_type;
        ctr_e                  count;
        virt_t                 target;
    } bht_entry_t;

endpackage

// ==== src/branch_predictor.sv ====
`timescale 1ns/1ps
`include "bpu_params.svh"

module branch_predictor
    import branch_pkg::*;
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  fetch_req_t  fetch_req,
    output logic        fetch_ready,
    output prediction_t prediction,
    input  verify_t     verify,
    output redirect_t   redirect
);

    typedef enum logic {
        st_idle    = 1'b0,
        st_correct = 1'b1
    } state_e;

    state_e      state;
    virt_t       correct_target_q;

    logic        accept;
    logic        mispredict;
    logic        hit;
    virt_t       pc_add8;

    bht_entry_t  rd_entry;
    bht_entry_t  wr_entry;

    logic        ras_push;
    logic        ras_pop;
    virt_t       ras_top;
    logic        ras_empty;

    prediction_t next_pred;
    prediction_t pred_q;
    logic        pred_valid;

    assign fetch_ready = (state == st_idle);
    assign accept      = fetch_req.valid && fetch_ready;
    assign mispredict  = verify.valid && !verify.predict_ok;
    assign pc_add8     = fetch_req.pc + `BPU_ADDR_W'd8;

    bht_ram i_bht_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (verify.valid),
        .waddr (verify.pc[`BHT_IDX_W+1:2]),
        .wdata (wr_entry),
        .raddr (fetch_req.pc[`BHT_IDX_W+1:2]),
        .rdata (rd_entry)
    );

    // calls push the return point past the delay slot
    return_stack i_return_stack (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_data (pc_add8),
        .top       (ras_top),
        .empty     (ras_empty)
    );

    // entry written back on verify
    always_comb begin
        wr_entry         = '0;
        wr_entry.tag     = verify.pc[`BPU_ADDR_W-1:`BHT_IDX_W+2];
        wr_entry.br_type = verify.actual_type;
        wr_entry.target  = verify.correct_target;
        if (verify.predict_ok) begin
            // step one toward the outcome, saturating
            case (verify.entry.count)
                ctr_snt: wr_entry.count = verify.taken ? ctr_wnt : ctr_snt;
                ctr_wnt: wr_entry.count = verify.taken ? ctr_wt  : ctr_snt;
                ctr_wt:  wr_entry.count = verify.taken ? ctr_st  : ctr_wnt;
                default: wr_entry.count = verify.taken ? ctr_st  : ctr_wt;
            endcase
        end else begin
            wr_entry.count = verify.taken ? ctr_wt : ctr_wnt;
        end
    end

    assign hit = (rd_entry.tag == fetch_req.pc[`BPU_ADDR_W-1:`BHT_IDX_W+2]) &&
                 (rd_entry.br_type != br_none);

    // lookup and target selection
    always_comb begin
        next_pred        = '0;
        next_pred.valid  = accept;
        next_pred.pc     = fetch_req.pc;
        next_pred.entry  = rd_entry;
        next_pred.br_op  = hit;
        next_pred.taken  = 1'b0;
        next_pred.target = pc_add8;
        ras_push         = 1'b0;
        ras_pop          = 1'b0;
        if (hit) begin
            case (rd_entry.br_type)
                br_jump: begin
                    next_pred.taken  = 1'b1;
                    next_pred.target = rd_entry.target;
                end
                br_call: begin
                    next_pred.taken  = 1'b1;
                    next_pred.target = rd_entry.target;
                    ras_push         = accept;
                end
                br_cond: begin
                    if (rd_entry.count[1]) begin
                        next_pred.taken  = 1'b1;
                        next_pred.target = rd_entry.target;
                    end
                end
                br_return: begin
                    // empty stack falls back to pc+8
                    if (!ras_empty) begin
                        next_pred.taken  = 1'b1;
                        next_pred.target = ras_top;
                        ras_pop          = accept;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // idle/correction FSM
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= st_idle;
        end else if (state == st_correct) begin
            state <= st_idle;
        end else if (mispredict) begin
            state <= st_correct;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && mispredict) begin
            correct_target_q <= verify.correct_target;
        end
    end

    // a flush in the correction cycle still kills the redirect
    assign redirect.valid  = (state == st_correct) && !flush;
    assign redirect.target = correct_target_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pred_q <= next_pred;
        end
    end

    always_comb begin
        prediction       = pred_q;
        prediction.valid = pred_valid;
    end

endmodule

// ==== src/bus_pkg.sv ====
`include "bpu_params.svh"

package bus_pkg;

    import branch_pkg::*;

    // fetch stage lookup request
    typedef struct packed {
        logic  valid;
        virt_t pc;
    } fetch_req_t;

    // registered answer to fetch, one cycle after the request
    typedef struct packed {
        logic       valid;
        virt_t      pc;
        logic       br_op;
        logic       taken;
        virt_t      target;
        bht_entry_t entry;
    } prediction_t;

    // resolved branch from execute
    // entry is the one handed out with the prediction
    typedef struct packed {
        logic       valid;
        virt_t      pc;
        bht_entry_t entry;
        br_type_e   actual_type;
        logic       taken;
        virt_t      correct_target;
        logic       predict_ok;
    } verify_t;

    // fetch redirect after a mispredict
    typedef struct packed {
        logic  valid;
        virt_t target;
    } redirect_t;

endpackage

// ==== src/return_stack.sv ====
`timescale 1ns/1ps
`include "bpu_params.svh"

module return_stack
    import branch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  logic  pop,
    input  virt_t push_data,
    output virt_t top,
    output logic  empty
);

    localparam int CNT_W = `RAS_PTR_W + 1;

    virt_t mem [`RAS_DEPTH];

    // ptr points at the next free slot
    logic [`RAS_PTR_W-1:0] ptr;
    logic [`RAS_PTR_W-1:0] top_ptr;
    logic [CNT_W-1:0]      count;
    logic                  full;

    assign top_ptr = ptr - 1'b1;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(`RAS_DEPTH));
    assign top     = mem[top_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
        end else if (push) begin
            ptr <= ptr + 1'b1;
            // when full the oldest slot gets overwritten
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop && !empty) begin
            ptr   <= top_ptr;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[ptr] <= push_data;
        end
    end

endmodule
